//--- Makefile
TOP := tb_amiga_video_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -qx "sim passed" sim.log

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- hw/amiga_video_cfg.svh
// constants shared by the bridge registers and the video output path
// include wherever an address, width, box or colour is needed
`ifndef AMIGA_VIDEO_CFG_SVH
`define AMIGA_VIDEO_CFG_SVH

// host bridge
`define AV_BRIDGE_W   32
`define AV_VIDEO_BASE 24'h200000   // upper address bits of the video window
`define AV_REG_XOFS   8'h00
`define AV_REG_YOFS   8'h04

// video path widths
`define AV_OFS_W      8
`define AV_CNT_W      10
`define AV_HS_DELAY   4            // hsync delay stages to the scaler

// drive led squares, rows shared by both boxes
`define AV_BOX_Y_LO   5
`define AV_BOX_Y_HI   15
`define AV_FDD_X_LO   5
`define AV_FDD_X_HI   15
`define AV_HDD_X_LO   20
`define AV_HDD_X_HI   35
`define AV_LED_LEVEL  8'hF0

`endif

//--- hw/amiga_video_pkg.sv
// types shared by the bridge decoder, the offset registers and the video path
// modules pull these in with a wildcard import
`include "amiga_video_cfg.svh"

package amiga_video_pkg;

	// host bridge request, plain one-cycle strobes
	typedef struct packed {
		logic [`AV_BRIDGE_W-1:0] addr;
		logic                    rd;
		logic                    wr;
		logic [`AV_BRIDGE_W-1:0] wr_data;
	} bridge_req_t;

	typedef enum logic {
		dev_none,
		dev_video_regs
	} bus_dev_e;

	// picture as it leaves the chipset, syncs active low
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		logic       hs;
		logic       vs;
		logic       hblank;
		logic       vblank;
		logic       lace;
		logic       field1;
		logic [1:0] res;
	} core_video_t;

	typedef struct packed {
		logic hs_fall;
		logic vs_fall;
		logic hblank_rise;
		logic active;
	} video_event_t;

	typedef enum logic [1:0] {
		src_picture,
		src_fdd_led,
		src_hdd_led
	} pixel_src_e;

	typedef struct packed {
		logic [23:0] rgb;
		logic        de;
		logic        vs;
		logic        hs;
	} scaler_video_t;

endpackage

//--- hw/amiga_video_top.sv
// video output path of the amiga core with its host bridge registers
// the host sets picture offsets over the bridge, the core picture comes
// in raw and leaves formatted for the scaler
`timescale 1ns/10ps
`include "amiga_video_cfg.svh"

module amiga_video_top import amiga_video_pkg::*; (
	input  logic                    clk_74a,
	input  logic                    cpu_rst,
	input  bridge_req_t             bridge,
	output logic [`AV_BRIDGE_W-1:0] bridge_rd_data,
	input  core_video_t             core_video,
	input  logic                    fdd_led,
	input  logic                    hdd_led,
	output scaler_video_t           scaler
);

	logic [`AV_BRIDGE_W-1:0] video_regs_rd_data;
	logic [`AV_OFS_W-1:0]    x_offset;
	logic [`AV_OFS_W-1:0]    y_offset;
	video_event_t            events;
	pixel_src_e              pixel_src;
	logic                    frame_lace;
	logic                    frame_field;
	logic [2:0]              frame_res;
	logic                    de;

	////////////////////////////////////////////////////////////
	// host bridge side

	bridge_decoder u_bridge_decoder (
		.clk_74a            (clk_74a),
		.cpu_rst            (cpu_rst),
		.bus                (bridge),
		.video_regs_rd_data (video_regs_rd_data),
		.bridge_rd_data     (bridge_rd_data)
	);

	video_offset_regs u_video_offset_regs (
		.clk_74a  (clk_74a),
		.cpu_rst  (cpu_rst),
		.bus      (bridge),
		.rd_data  (video_regs_rd_data),
		.x_offset (x_offset),
		.y_offset (y_offset)
	);

	////////////////////////////////////////////////////////////
	// video side

	video_timing_tracker u_video_timing_tracker (
		.clk_74a     (clk_74a),
		.cpu_rst     (cpu_rst),
		.core        (core_video),
		.x_offset    (x_offset),
		.y_offset    (y_offset),
		.fdd_led     (fdd_led),
		.hdd_led     (hdd_led),
		.events      (events),
		.pixel_src   (pixel_src),
		.frame_lace  (frame_lace),
		.frame_field (frame_field),
		.frame_res   (frame_res),
		.de          (de)
	);

	video_output_formatter u_video_output_formatter (
		.clk_74a     (clk_74a),
		.cpu_rst     (cpu_rst),
		.core        (core_video),
		.events      (events),
		.pixel_src   (pixel_src),
		.frame_lace  (frame_lace),
		.frame_field (frame_field),
		.frame_res   (frame_res),
		.de          (de),
		.scaler      (scaler)
	);

endmodule

//--- hw/bridge_decoder.sv
// read side of the host bridge
// picks the device from the address and returns its read data,
// unmapped addresses read back as zero
`timescale 1ns/10ps
`include "amiga_video_cfg.svh"

module bridge_decoder import amiga_video_pkg::*; (
	input  logic                    clk_74a,
	input  logic                    cpu_rst,
	input  bridge_req_t             bus,
	input  logic [`AV_BRIDGE_W-1:0] video_regs_rd_data,
	output logic [`AV_BRIDGE_W-1:0] bridge_rd_data
);

	bus_dev_e dev_sel;

	////////////////////////////////////////////////////////////
	// address decode

	always_comb begin
		if (bus.addr[`AV_BRIDGE_W-1:8] == `AV_VIDEO_BASE) begin
			dev_sel = dev_video_regs;
		end else begin
			dev_sel = dev_none;
		end
	end

	////////////////////////////////////////////////////////////
	// read data mux, follows the live address

	always_comb begin
		case (dev_sel)
			dev_video_regs: bridge_rd_data = video_regs_rd_data;
			default:        bridge_rd_data = '0;   // unmapped
		endcase
	end

	// the host issues one access at a time
	a_no_rd_wr_overlap: assert property (
		@(posedge clk_74a) disable iff (!cpu_rst)
		!(bus.rd && bus.wr)
	) else $error("bridge rd and wr strobes high together");

endmodule

//--- hw/video_offset_regs.sv
// horizontal and vertical picture offsets, written and read by the host
// readback goes through two register stages, so data shows up on the
// bridge two edges after the read strobe
`timescale 1ns/10ps
`include "amiga_video_cfg.svh"

module video_offset_regs import amiga_video_pkg::*; (
	input  logic                    clk_74a,
	input  logic                    cpu_rst,
	input  bridge_req_t             bus,
	output logic [`AV_BRIDGE_W-1:0] rd_data,
	output logic [`AV_OFS_W-1:0]    x_offset,
	output logic [`AV_OFS_W-1:0]    y_offset
);

	localparam int PAD_W = `AV_BRIDGE_W - `AV_OFS_W;

	logic                    win_hit;
	logic [`AV_BRIDGE_W-1:0] rd_q;   // first readback stage

	assign win_hit = (bus.addr[`AV_BRIDGE_W-1:8] == `AV_VIDEO_BASE);

	////////////////////////////////////////////////////////////
	// register writes

	always_ff @(posedge clk_74a) begin
		if (!cpu_rst) begin
			x_offset <= '0;
			y_offset <= '0;
		end else if (bus.wr && win_hit) begin
			case (bus.addr[7:0])
				`AV_REG_XOFS: x_offset <= bus.wr_data[`AV_OFS_W-1:0];
				`AV_REG_YOFS: y_offset <= bus.wr_data[`AV_OFS_W-1:0];
				default: ;   // other offsets ignored
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// readback

	always_ff @(posedge clk_74a) begin
		if (!cpu_rst) begin
			rd_q    <= '0;
			rd_data <= '0;
		end else begin
			if (bus.rd && win_hit) begin
				case (bus.addr[7:0])
					`AV_REG_XOFS: rd_q <= {{PAD_W{1'b0}}, x_offset};
					`AV_REG_YOFS: rd_q <= {{PAD_W{1'b0}}, y_offset};
					default: ;   // keep last value
				endcase
			end
			rd_data <= rd_q;
		end
	end

endmodule

//--- hw/video_output_formatter.sv
// builds the scaler stream: picture or led overlay during active video,
// the interlace marker on vsync and the resolution marker at hblank start
// hsync goes out through a short delay chain
`timescale 1ns/10ps
`include "amiga_video_cfg.svh"

module video_output_formatter import amiga_video_pkg::*; (
	input  logic          clk_74a,
	input  logic          cpu_rst,
	input  core_video_t   core,
	input  video_event_t  events,
	input  pixel_src_e    pixel_src,
	input  logic          frame_lace,
	input  logic          frame_field,
	input  logic [2:0]    frame_res,
	input  logic          de,
	output scaler_video_t scaler
);

	logic [23:0]             rgb_q;
	logic                    vs_q;
	logic                    hs_q;
	logic [`AV_HS_DELAY-1:0] hs_pipe;   // hsync delay stages
	logic [2:0]              lace_mark;

	// scaler reads this as odd/even/progressive
	assign lace_mark = {frame_field & frame_lace, frame_lace, ~frame_field & frame_lace};

	////////////////////////////////////////////////////////////
	// rgb priority and vsync

	always_ff @(posedge clk_74a) begin
		if (!cpu_rst) begin
			rgb_q <= '0;
			vs_q  <= 1'b0;
		end else begin
			vs_q <= events.vs_fall;
			if (events.vs_fall) begin
				rgb_q <= {21'd0, lace_mark};
			end else if (events.active) begin
				case (pixel_src)
					src_fdd_led: rgb_q <= {8'h00, `AV_LED_LEVEL, 8'h00};   // green
					src_hdd_led: rgb_q <= {`AV_LED_LEVEL, 16'h0000};       // red
					default:     rgb_q <= {core.r, core.g, core.b};
				endcase
			end else if (events.hblank_rise) begin
				rgb_q <= {8'd0, frame_res, 13'd0};   // resolution in bits 15:13
			end else begin
				rgb_q <= '0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// hsync delay chain

	always_ff @(posedge clk_74a) begin
		if (!cpu_rst) begin
			hs_pipe <= '0;
			hs_q    <= 1'b0;
		end else begin
			hs_pipe <= {hs_pipe[`AV_HS_DELAY-2:0], events.hs_fall};
			hs_q    <= hs_pipe[`AV_HS_DELAY-1];
		end
	end

	assign scaler = '{rgb: rgb_q, de: de, vs: vs_q, hs: hs_q};

	// marker cycle must not be taken as a pixel
	a_vs_not_de: assert property (
		@(posedge clk_74a) disable iff (!cpu_rst)
		!(scaler.vs && scaler.de)
	) else $error("video_vs and video_de high together");

endmodule

//--- hw/video_timing_tracker.sv
// follows the core's syncs and blanks, counts pixels and lines and
// applies the picture offsets to produce data enable
// also captures per-frame lace/field/resolution and picks the led overlay
`timescale 1ns/10ps
`include "amiga_video_cfg.svh"

module video_timing_tracker import amiga_video_pkg::*; (
	input  logic                 clk_74a,
	input  logic                 cpu_rst,
	input  core_video_t          core,
	input  logic [`AV_OFS_W-1:0] x_offset,
	input  logic [`AV_OFS_W-1:0] y_offset,
	input  logic                 fdd_led,
	input  logic                 hdd_led,
	output video_event_t         events,
	output pixel_src_e           pixel_src,
	output logic                 frame_lace,
	output logic                 frame_field,
	output logic [2:0]           frame_res,
	output logic                 de
);

	logic                 hs_q, vs_q, hblank_q;   // sync history
	logic                 de_q;
	logic [`AV_CNT_W-1:0] x_cnt, y_cnt;
	logic [`AV_OFS_W-1:0] x_cd, y_cd;             // offset countdowns
	logic                 in_rows;

	////////////////////////////////////////////////////////////
	// edge events in the same cycle as the input change

	always_comb begin
		events.hs_fall     = hs_q & ~core.hs;
		events.vs_fall     = vs_q & ~core.vs;
		events.hblank_rise = core.hblank & ~hblank_q;
		events.active      = ~core.hblank & ~core.vblank & ~events.vs_fall;
	end

	////////////////////////////////////////////////////////////
	// counters, countdowns and frame capture

	always_ff @(posedge clk_74a) begin
		if (!cpu_rst) begin
			hs_q        <= 1'b0;
			vs_q        <= 1'b0;
			hblank_q    <= 1'b0;
			de          <= 1'b0;
			de_q        <= 1'b0;
			x_cnt       <= '0;
			y_cnt       <= '0;
			x_cd        <= '0;
			y_cd        <= '0;
			frame_lace  <= 1'b0;
			frame_field <= 1'b0;
			frame_res   <= '0;
		end else begin
			hs_q     <= core.hs;
			vs_q     <= core.vs;
			hblank_q <= core.hblank;
			de_q     <= de;
			de       <= events.active && x_cd == '0 && y_cd == '0;

			if (de) x_cnt <= x_cnt + 1'b1;
			if (de && !de_q) y_cnt <= y_cnt + 1'b1;   // new visible line

			if (events.hs_fall) begin
				x_cnt       <= '0;
				x_cd        <= x_offset;
				frame_field <= core.field1;
				if (y_cd != '0) y_cd <= y_cd - 1'b1;
			end else if (events.active && x_cd != '0) begin
				x_cd <= x_cd - 1'b1;
			end

			if (events.vs_fall) begin
				y_cd       <= y_offset;
				y_cnt      <= '0;
				frame_lace <= core.lace;
				frame_res  <= {core.lace, core.res};
			end
		end
	end

	////////////////////////////////////////////////////////////
	// led overlay choice from the counters before update

	assign in_rows = y_cnt >= `AV_BOX_Y_LO && y_cnt <= `AV_BOX_Y_HI;

	always_comb begin
		pixel_src = src_picture;
		if (in_rows && fdd_led && x_cnt >= `AV_FDD_X_LO && x_cnt <= `AV_FDD_X_HI)
			pixel_src = src_fdd_led;
		else if (in_rows && hdd_led && x_cnt >= `AV_HDD_X_LO && x_cnt <= `AV_HDD_X_HI)
			pixel_src = src_hdd_led;
	end

	// lines above the vertical offset stay dark
	a_de_after_y_offset: assert property (
		@(posedge clk_74a) disable iff (!cpu_rst)
		$rose(de) |-> y_cd == '0
	) else $error("de rose while vertical offset still counting");

endmodule

//--- verification/tb_amiga_video_top.sv
// directed testbench for the amiga video path and its bridge registers
// drives host bridge accesses and a synthetic core picture, then checks
// every scaler cycle against a model kept from the capture rules
`timescale 1ns/10ps
`include "amiga_video_cfg.svh"

module tb_amiga_video_top import amiga_video_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int HB         = 8;    // blank cycles at line start
	localparam int ACT        = 44;
	localparam int LINE_LEN   = HB + ACT;
	localparam int N_LINES    = 18;   // lines after the vsync line
	localparam int X_OFS      = 3;
	localparam int Y_OFS      = 1;
	// two frames plus the short tests and some margin
	localparam int RUN_CYCLES = 2 * ((N_LINES + 1) * LINE_LEN + 8) + 200 + 500;
	localparam logic [31:0] XOFS_ADDR = {`AV_VIDEO_BASE, `AV_REG_XOFS};
	localparam logic [31:0] YOFS_ADDR = {`AV_VIDEO_BASE, `AV_REG_YOFS};

	logic          clk_74a = 1'b0;
	logic          cpu_rst;
	bridge_req_t   bridge;
	logic [31:0]   bridge_rd_data;
	core_video_t   core_video;
	logic          fdd_led;
	logic          hdd_led;
	scaler_video_t scaler;

	logic [31:0] lfsr;
	logic        prev_hs, prev_vs, prev_hblank;   // expected sync history
	logic        cap_lace, cap_field;
	logic [2:0]  cap_res;
	int          cyc, last_hs_fall;

	amiga_video_top u_amiga_video_top (
		.clk_74a        (clk_74a),
		.cpu_rst        (cpu_rst),
		.bridge         (bridge),
		.bridge_rd_data (bridge_rd_data),
		.core_video     (core_video),
		.fdd_led        (fdd_led),
		.hdd_led        (hdd_led),
		.scaler         (scaler)
	);

	initial begin
		forever #(CLK_PERIOD / 2) clk_74a = ~clk_74a;
	end

	initial begin
		#(RUN_CYCLES * CLK_PERIOD);
		$display("watchdog expired before all tests finished");
		$display("sim failed");
		$fatal(1);
	end

	////////////////////////////////////////////////////////////
	// helpers

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val  = {val[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return val;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	// drives one pixel after the falling edge and checks the registered result
	task automatic video_cycle(input logic hs, input logic vs, input logic hblank,
			input logic vblank, input logic want_de, input pixel_src_e src);
		logic [31:0] pix;
		logic        vs_fall, active;
		logic [23:0] exp_rgb;
		pix = rand_bits(24);
		core_video.r      = pix[23:16];
		core_video.g      = pix[15:8];
		core_video.b      = pix[7:0];
		core_video.hs     = hs;
		core_video.vs     = vs;
		core_video.hblank = hblank;
		core_video.vblank = vblank;
		vs_fall = prev_vs & ~vs;
		active  = ~hblank & ~vblank & ~vs_fall;
		if (vs_fall)
			exp_rgb = {21'd0, cap_field & cap_lace, cap_lace, ~cap_field & cap_lace};
		else if (active && src == src_fdd_led)
			exp_rgb = {8'h00, `AV_LED_LEVEL, 8'h00};
		else if (active && src == src_hdd_led)
			exp_rgb = {`AV_LED_LEVEL, 16'h0000};
		else if (active)
			exp_rgb = pix[23:0];
		else if (hblank && !prev_hblank)
			exp_rgb = {8'd0, cap_res, 13'd0};
		else
			exp_rgb = '0;
		if (prev_hs && !hs) begin
			cap_field    = core_video.field1;
			last_hs_fall = cyc;
		end
		if (vs_fall) begin
			cap_lace = core_video.lace;
			cap_res  = {core_video.lace, core_video.res};
		end
		prev_hs     = hs;
		prev_vs     = vs;
		prev_hblank = hblank;
		@(negedge clk_74a);
		check_value("video_rgb", {8'd0, exp_rgb}, {8'd0, scaler.rgb});
		check_value("video_de", 32'(want_de), 32'(scaler.de));
		check_value("video_vs", 32'(vs_fall), 32'(scaler.vs));
		check_value("video_hs", 32'(cyc - last_hs_fall == `AV_HS_DELAY), 32'(scaler.hs));
		cyc++;
	endtask

	task automatic idle(input int n);
		repeat (n) video_cycle(1'b1, 1'b1, 1'b1, 1'b1, 1'b0, src_picture);
	endtask

	task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
		bridge.addr    = addr;
		bridge.wr_data = data;
		bridge.wr      = 1'b1;
		@(negedge clk_74a);
		bridge.wr = 1'b0;
	endtask

	// address held until the data is due two edges after the strobe
	task automatic bridge_read_check(input logic [31:0] addr, input logic [31:0] expected);
		bridge.addr = addr;
		bridge.rd   = 1'b1;
		@(negedge clk_74a);
		bridge.rd = 1'b0;
		@(negedge clk_74a);
		check_value("bridge_rd_data", expected, bridge_rd_data);
	endtask

	task automatic reset_dut();
		cpu_rst           = 1'b0;
		bridge            = '0;
		core_video        = '0;
		core_video.hs     = 1'b1;   // syncs idle high
		core_video.vs     = 1'b1;
		core_video.hblank = 1'b1;
		core_video.vblank = 1'b1;
		fdd_led           = 1'b0;
		hdd_led           = 1'b0;
		lfsr              = 32'h02399d4a;
		prev_hs           = 1'b0;
		prev_vs           = 1'b0;
		prev_hblank       = 1'b0;
		cap_lace          = 1'b0;
		cap_field         = 1'b0;
		cap_res           = '0;
		cyc               = 0;
		last_hs_fall      = -100;
		repeat (2) @(negedge clk_74a);
		cpu_rst = 1'b1;
		idle(2);
	endtask

	////////////////////////////////////////////////////////////
	// directed tests

	task automatic test_register_access();
		logic [31:0] xv, yv;
		repeat (4) begin
			xv = rand_bits(32);
			yv = rand_bits(32);
			bridge_write(XOFS_ADDR, xv);
			bridge_write(YOFS_ADDR, yv);
			bridge_read_check(XOFS_ADDR, {24'd0, xv[7:0]});
			bridge_read_check(YOFS_ADDR, {24'd0, yv[7:0]});
		end
	endtask

	// readback register left holding a nonzero value before the unmapped reads
	task automatic test_unmapped_reads();
		bridge_write(XOFS_ADDR, 32'h000000a5);
		bridge_read_check(XOFS_ADDR, 32'h000000a5);
		bridge_read_check(32'h30000000, '0);
		bridge_read_check(32'h20000100, '0);   // just past the video window
		bridge_read_check(32'h00000004, '0);
	endtask

	// lace comes from one vsync and field from the next hsync before the marker vsync
	task automatic test_vsync_marker();
		for (int i = 0; i < 4; i++) begin
			core_video.lace   = i[1];
			core_video.field1 = i[0];
			video_cycle(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, src_picture);
			idle(1);
			video_cycle(1'b0, 1'b1, 1'b1, 1'b1, 1'b0, src_picture);
			idle(6);
			repeat (3) video_cycle(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, src_picture);
			idle(2);
		end
	endtask

	task automatic test_sync_delay();
		video_cycle(1'b0, 1'b1, 1'b1, 1'b1, 1'b0, src_picture);
		idle(`AV_HS_DELAY + 3);
		repeat (3) video_cycle(1'b0, 1'b1, 1'b1, 1'b1, 1'b0, src_picture);   // long hsync
		idle(`AV_HS_DELAY + 3);
	endtask

	task automatic run_frame(input logic fdd, input logic hdd, input logic lace,
			input logic [1:0] res);
		int         k, row, col;
		pixel_src_e src;
		fdd_led         = fdd;
		hdd_led         = hdd;
		core_video.lace = lace;
		core_video.res  = res;
		// vsync line without de while the vertical offset counts down
		for (int i = 0; i < LINE_LEN; i++)
			video_cycle(1'b1, i != 1, i < HB, 1'b0, 1'b0, src_picture);
		for (int n = 1; n <= N_LINES; n++) begin
			for (int i = 0; i < LINE_LEN; i++) begin
				k   = i - HB - X_OFS;           // de pixel index in the line
				row = (k < 2) ? n - 1 : n;       // line count steps after de rises
				col = (k < 1) ? 0 : k - 1;
				src = src_picture;
				if (k >= 0 && row >= `AV_BOX_Y_LO && row <= `AV_BOX_Y_HI) begin
					if (fdd && col >= `AV_FDD_X_LO && col <= `AV_FDD_X_HI)
						src = src_fdd_led;
					else if (hdd && col >= `AV_HDD_X_LO && col <= `AV_HDD_X_HI)
						src = src_hdd_led;
				end
				video_cycle(!(i == 2 || i == 3), 1'b1, i < HB, 1'b0, k >= 0, src);
			end
		end
		idle(8);
	endtask

	task automatic test_picture_frames();
		bridge_write(XOFS_ADDR, X_OFS);
		bridge_write(YOFS_ADDR, Y_OFS);
		run_frame(1'b1, 1'b0, 1'b1, 2'd2);
		run_frame(1'b0, 1'b1, 1'b0, 2'd1);
	endtask

	initial begin
		reset_dut();
		test_register_access();
		test_unmapped_reads();
		test_vsync_marker();
		test_sync_delay();
		test_picture_frames();
		$display("sim passed");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+hw
hw/amiga_video_pkg.sv
hw/bridge_decoder.sv
hw/video_offset_regs.sv
hw/video_timing_tracker.sv
hw/video_output_formatter.sv
hw/amiga_video_top.sv
verification/tb_amiga_video_top.sv
